//--- logic/mips_pkg.sv
package mips_pkg;

   ////////////////////////////////////////////////////////////////////
   // Widths.
   ////////////////////////////////////////////////////////////////////

   localparam int XLEN       = 32;
   localparam int REG_COUNT  = 32;
   localparam int REG_ADDR_W = 5;
   localparam int IMM_W      = 16;

   ////////////////////////////////////////////////////////////////////
   // Instruction encodings.
   ////////////////////////////////////////////////////////////////////

   // Major opcodes, instr[31:26].
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_BEQ   = 6'h04,
      OP_ADDI  = 6'h08,
      OP_HALT  = 6'h3f
   } op_e;

   // R-type funct field, instr[5:0].
   localparam logic [5:0] FUNCT_ADD = 6'h20;
   localparam logic [5:0] FUNCT_SUB = 6'h22;
   localparam logic [5:0] FUNCT_AND = 6'h24;
   localparam logic [5:0] FUNCT_OR  = 6'h25;
   localparam logic [5:0] FUNCT_SLT = 6'h2a;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

   ////////////////////////////////////////////////////////////////////
   // Decoded instruction, 106 bits.
   ////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [XLEN-1:0]       opa;
      logic [XLEN-1:0]       opb;
      logic [XLEN-1:0]       imm;
      logic                  use_imm;
      alu_op_e               alu_op;
      logic [REG_ADDR_W-1:0] rd;
      logic                  we;
   } decoded_t;

endpackage

//--- logic/stage_if.sv
`timescale 1ns/1ps

// Decode to execute bundle.
interface stage_if
   import mips_pkg::*;
();

   logic [XLEN-1:0]       opa;
   logic [XLEN-1:0]       opb;
   logic [XLEN-1:0]       imm;
   logic                  use_imm;
   alu_op_e               alu_op;
   logic [REG_ADDR_W-1:0] rd;
   logic                  we;
   logic                  valid;

   modport src (
      output opa, opb, imm, use_imm,
      output alu_op, rd, we, valid
   );

   modport dst (
      input opa, opb, imm, use_imm,
      input alu_op, rd, we, valid
   );

endinterface

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
   import mips_pkg::*;
#(
   parameter int IMEM_AW = 8
) (
   input  logic               i_clock,
   input  logic               i_rst,
   input  logic               i_run,
   input  logic               i_load_req,
   input  logic [IMEM_AW-1:0] i_load_addr,
   input  logic [XLEN-1:0]    i_load_data,
   input  logic               i_halt,
   input  logic               i_br_taken,
   input  logic [IMEM_AW-1:0] i_br_target,
   output logic               o_load_ack,
   output logic [XLEN-1:0]    o_instr,
   output logic [IMEM_AW-1:0] o_pc_next,
   output logic               o_valid
);

   logic [XLEN-1:0]    imem [2**IMEM_AW];
   logic [IMEM_AW-1:0] pc;
   logic               stopped;
   logic               fetch_en;

   // Halt in decode squashes the word fetched alongside it.
   assign fetch_en = i_run && !stopped && !i_halt;

   always_ff @(posedge i_clock) begin
      if (i_rst) begin
         pc         <= '0;
         stopped    <= 1'b0;
         o_valid    <= 1'b0;
         o_load_ack <= 1'b0;
      end else begin
         o_load_ack <= i_load_req;
         o_valid    <= fetch_en;
         if (i_halt) begin
            stopped <= 1'b1;
         end
         if (!i_run) begin
            pc <= '0;
         end else if (fetch_en) begin
            // Taken beq lands here one cycle after its delay slot.
            pc <= i_br_taken ? i_br_target : pc + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Instruction memory.
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (i_load_req && !o_load_ack) begin
         imem[i_load_addr] <= i_load_data;
      end
      o_instr   <= imem[pc];
      o_pc_next <= pc + 1'b1;
   end

   a_ack_after_req : assert property (@(posedge i_clock) disable iff (i_rst)
      $rose(o_load_ack) |-> $past(i_load_req));

   a_no_load_while_run : assert property (@(posedge i_clock) disable iff (i_rst)
      i_run |-> !i_load_req);

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
   import mips_pkg::*;
#(
   parameter int IMEM_AW = 8
) (
   input  logic                  i_clock,
   input  logic                  i_rst,
   input  logic [XLEN-1:0]       i_instr,
   input  logic [IMEM_AW-1:0]    i_pc_next,
   input  logic                  i_valid,
   input  logic                  i_wb_we,
   input  logic [REG_ADDR_W-1:0] i_wb_reg,
   input  logic [XLEN-1:0]       i_wb_data,
   output logic                  o_halt,
   output logic                  o_br_taken,
   output logic [IMEM_AW-1:0]    o_br_target,
   stage_if.src                  o_dec
);

   logic [5:0]            opcode;
   op_e                   op;
   logic [REG_ADDR_W-1:0] rs;
   logic [REG_ADDR_W-1:0] rt;
   logic [REG_ADDR_W-1:0] rd;
   logic [5:0]            funct;
   logic [IMM_W-1:0]      imm;
   logic [XLEN-1:0]       imm_ext;
   logic [XLEN-1:0]       rs_val;
   logic [XLEN-1:0]       rt_val;
   logic [XLEN-1:0]       regs [REG_COUNT];
   decoded_t              dec_d;

   ////////////////////////////////////////////////////////////////////
   // Fields and register file.
   ////////////////////////////////////////////////////////////////////

   assign opcode  = i_instr[31:26];
   assign op      = op_e'(opcode);
   assign rs      = i_instr[25:21];
   assign rt      = i_instr[20:16];
   assign rd      = i_instr[15:11];
   assign funct   = i_instr[5:0];
   assign imm     = i_instr[IMM_W-1:0];
   assign imm_ext = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};

   always_ff @(posedge i_clock) begin
      if (i_rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb_we && i_wb_reg != '0) begin
         regs[i_wb_reg] <= i_wb_data;
      end
   end

   // Same-cycle writeback is forwarded to the reads.
   always_comb begin
      if (rs == '0)                       rs_val = '0;
      else if (i_wb_we && i_wb_reg == rs) rs_val = i_wb_data;
      else                                rs_val = regs[rs];
      if (rt == '0)                       rt_val = '0;
      else if (i_wb_we && i_wb_reg == rt) rt_val = i_wb_data;
      else                                rt_val = regs[rt];
   end

   // Branch target is relative to the delay slot.
   assign o_br_target = i_pc_next + imm_ext[IMEM_AW-1:0];
   assign o_br_taken  = i_valid && op == OP_BEQ && rs_val == rt_val;
   assign o_halt      = i_valid && op == OP_HALT;

   ////////////////////////////////////////////////////////////////////
   // Control decode.
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      dec_d         = '0;
      dec_d.opa     = rs_val;
      dec_d.opb     = rt_val;
      dec_d.imm     = imm_ext;
      dec_d.alu_op  = ALU_ADD;
      case (op)
         OP_RTYPE: begin
            dec_d.rd = rd;
            dec_d.we = 1'b1;
            case (funct)
               FUNCT_ADD: dec_d.alu_op = ALU_ADD;
               FUNCT_SUB: dec_d.alu_op = ALU_SUB;
               FUNCT_AND: dec_d.alu_op = ALU_AND;
               FUNCT_OR:  dec_d.alu_op = ALU_OR;
               FUNCT_SLT: dec_d.alu_op = ALU_SLT;
               default:   dec_d.we = 1'b0;
            endcase
         end
         OP_ADDI: begin
            dec_d.rd      = rt;
            dec_d.use_imm = 1'b1;
            dec_d.we      = 1'b1;
         end
         default: dec_d.we = 1'b0;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (i_rst) o_dec.valid <= 1'b0;
      else       o_dec.valid <= i_valid;
   end

   always_ff @(posedge i_clock) begin
      o_dec.opa     <= dec_d.opa;
      o_dec.opb     <= dec_d.opb;
      o_dec.imm     <= dec_d.imm;
      o_dec.use_imm <= dec_d.use_imm;
      o_dec.alu_op  <= dec_d.alu_op;
      o_dec.rd      <= dec_d.rd;
      o_dec.we      <= dec_d.we;
   end

   a_known_opcode : assert property (@(posedge i_clock) disable iff (i_rst)
      i_valid |-> opcode inside {OP_RTYPE, OP_ADDI, OP_BEQ, OP_HALT});

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
   import mips_pkg::*;
(
   input  logic                  i_clock,
   input  logic                  i_rst,
   stage_if.dst                  i_dec,
   output logic                  o_wb_we,
   output logic [REG_ADDR_W-1:0] o_wb_reg,
   output logic [XLEN-1:0]       o_wb_data
);

   logic [XLEN-1:0] src_b;
   logic [XLEN-1:0] alu_res;
   logic            slt_bit;

   ////////////////////////////////////////////////////////////////////
   // ALU.
   ////////////////////////////////////////////////////////////////////

   assign src_b   = i_dec.use_imm ? i_dec.imm : i_dec.opb;
   // Signed compare for slt.
   assign slt_bit = $signed(i_dec.opa) < $signed(src_b);

   always_comb begin
      case (i_dec.alu_op)
         ALU_ADD: alu_res = i_dec.opa + src_b;
         ALU_SUB: alu_res = i_dec.opa - src_b;
         ALU_AND: alu_res = i_dec.opa & src_b;
         ALU_OR:  alu_res = i_dec.opa | src_b;
         ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, slt_bit};
         default: alu_res = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // Writeback register.
   ////////////////////////////////////////////////////////////////////

   // Writes to r0 are dropped here and never leave the core.
   always_ff @(posedge i_clock) begin
      if (i_rst) begin
         o_wb_we <= 1'b0;
      end else begin
         o_wb_we <= i_dec.valid && i_dec.we && i_dec.rd != '0;
      end
   end

   always_ff @(posedge i_clock) begin
      o_wb_reg  <= i_dec.rd;
      o_wb_data <= alu_res;
   end

   a_no_r0_write : assert property (@(posedge i_clock) disable iff (i_rst)
      o_wb_we |-> o_wb_reg != '0);

endmodule

//--- logic/mips_core.sv
`timescale 1ns/1ps

module mips_core
   import mips_pkg::*;
#(
   parameter int IMEM_AW = 8
) (
   input  logic                  i_clock,
   input  logic                  i_rst,
   input  logic                  i_run,
   input  logic                  i_load_req,
   input  logic [IMEM_AW-1:0]    i_load_addr,
   input  logic [XLEN-1:0]       i_load_data,
   output logic                  o_load_ack,
   output logic                  o_wb_valid,
   output logic [REG_ADDR_W-1:0] o_wb_reg,
   output logic [XLEN-1:0]       o_wb_data,
   output logic                  o_halted
);

   logic [XLEN-1:0]       if_instr;
   logic [IMEM_AW-1:0]    if_pc_next;
   logic                  if_valid;
   logic                  dec_halt;
   logic                  br_taken;
   logic [IMEM_AW-1:0]    br_target;
   logic                  wb_we;
   logic [REG_ADDR_W-1:0] wb_reg;
   logic [XLEN-1:0]       wb_data;
   logic [1:0]            drain;

   stage_if u_dec_bus ();

   fetch_stage #(
      .IMEM_AW (IMEM_AW)
   ) u_fetch (
      .i_clock     (i_clock),
      .i_rst       (i_rst),
      .i_run       (i_run),
      .i_load_req  (i_load_req),
      .i_load_addr (i_load_addr),
      .i_load_data (i_load_data),
      .i_halt      (dec_halt),
      .i_br_taken  (br_taken),
      .i_br_target (br_target),
      .o_load_ack  (o_load_ack),
      .o_instr     (if_instr),
      .o_pc_next   (if_pc_next),
      .o_valid     (if_valid)
   );

   decode_stage #(
      .IMEM_AW (IMEM_AW)
   ) u_decode (
      .i_clock     (i_clock),
      .i_rst       (i_rst),
      .i_instr     (if_instr),
      .i_pc_next   (if_pc_next),
      .i_valid     (if_valid),
      .i_wb_we     (wb_we),
      .i_wb_reg    (wb_reg),
      .i_wb_data   (wb_data),
      .o_halt      (dec_halt),
      .o_br_taken  (br_taken),
      .o_br_target (br_target),
      .o_dec       (u_dec_bus.src)
   );

   execute_stage u_execute (
      .i_clock   (i_clock),
      .i_rst     (i_rst),
      .i_dec     (u_dec_bus.dst),
      .o_wb_we   (wb_we),
      .o_wb_reg  (wb_reg),
      .o_wb_data (wb_data)
   );

   assign o_wb_valid = wb_we;
   assign o_wb_reg   = wb_reg;
   assign o_wb_data  = wb_data;

   ////////////////////////////////////////////////////////////////////
   // Halt drain.
   ////////////////////////////////////////////////////////////////////

   // Two stages behind decode, sticky until reset.
   always_ff @(posedge i_clock) begin
      if (i_rst) begin
         drain <= 2'b00;
      end else begin
         drain <= {drain[0], drain[0] | dec_halt};
      end
   end

   assign o_halted = drain[1];

   a_quiet_after_halt : assert property (@(posedge i_clock) disable iff (i_rst)
      o_halted |-> !o_wb_valid);

endmodule

//--- tb/mips_ref_model.sv
`timescale 1ns/1ps

// Instruction-level model of the core that runs one instruction per step.
module mips_ref_model
   import mips_pkg::*;
#(
   parameter int DEPTH = 64
) ();

   logic [XLEN-1:0]       imem [DEPTH];
   logic [XLEN-1:0]       regs [REG_COUNT];
   logic [REG_ADDR_W-1:0] reg_q [$];
   logic [XLEN-1:0]       data_q [$];

   task automatic clear();
      for (int i = 0; i < DEPTH; i++) begin
         imem[i] = {OP_HALT, 26'(i)};
      end
      reg_q.delete();
      data_q.delete();
   endtask

   task automatic load(input int addr, input logic [XLEN-1:0] word);
      imem[addr % DEPTH] = word;
   endtask

   // The pc/npc pair gives the branch its delay slot.
   task automatic run();
      int                    pc;
      int                    npc;
      int                    nnpc;
      int                    offset;
      int                    steps;
      logic [XLEN-1:0]       w;
      logic [XLEN-1:0]       a;
      logic [XLEN-1:0]       b;
      logic [XLEN-1:0]       res;
      logic [REG_ADDR_W-1:0] dst;
      bit                    wr;
      bit                    done;
      for (int i = 0; i < REG_COUNT; i++) begin
         regs[i] = '0;
      end
      pc    = 0;
      npc   = 1;
      steps = 0;
      done  = 1'b0;
      while (!done && steps < 4 * DEPTH) begin
         w      = imem[pc % DEPTH];
         a      = regs[w[25:21]];
         b      = regs[w[20:16]];
         offset = $signed(w[15:0]);
         nnpc   = npc + 1;
         wr     = 1'b0;
         dst    = w[15:11];
         res    = '0;
         case (w[31:26])
            OP_RTYPE: begin
               wr = 1'b1;
               case (w[5:0])
                  FUNCT_ADD: res = a + b;
                  FUNCT_SUB: res = a - b;
                  FUNCT_AND: res = a & b;
                  FUNCT_OR:  res = a | b;
                  FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default:   wr = 1'b0;
               endcase
            end
            OP_ADDI: begin
               wr  = 1'b1;
               dst = w[20:16];
               res = a + XLEN'(offset);
            end
            OP_BEQ: begin
               if (a == b) nnpc = pc + 1 + offset;
            end
            default: done = 1'b1;
         endcase
         // r0 stays zero.
         if (wr && dst != '0) begin
            regs[dst] = res;
            reg_q.push_back(dst);
            data_q.push_back(res);
         end
         pc    = npc;
         npc   = nnpc;
         steps = steps + 1;
      end
   endtask

   function automatic bit next_write(output logic [REG_ADDR_W-1:0] r,
                                     output logic [XLEN-1:0] d);
      r = '0;
      d = '0;
      if (reg_q.size() == 0) begin
         return 1'b0;
      end
      r = reg_q.pop_front();
      d = data_q.pop_front();
      return 1'b1;
   endfunction

endmodule

//--- tb/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core
   import mips_pkg::*;
();

   localparam int IMEM_AW = 8;
   localparam int NTESTS  = 4;
   localparam int MAXW    = 32;
   localparam logic [XLEN-1:0] NOP  = {OP_RTYPE, 20'd0, FUNCT_ADD};
   localparam logic [XLEN-1:0] HALT = {OP_HALT, 26'd0};

   logic                  clock;
   logic                  rst;
   logic                  run;
   logic                  load_req;
   logic [IMEM_AW-1:0]    load_addr;
   logic [XLEN-1:0]       load_data;
   logic                  load_ack;
   logic                  wb_valid;
   logic [REG_ADDR_W-1:0] wb_reg;
   logic [XLEN-1:0]       wb_data;
   logic                  halted;

   logic [XLEN-1:0]       progs [NTESTS][MAXW];
   int                    plen [NTESTS];
   string                 names [NTESTS];
   logic [REG_ADDR_W-1:0] exp_reg_q [$];
   logic [XLEN-1:0]       exp_data_q [$];
   int                    exp_count;
   logic [REG_ADDR_W-1:0] exp_reg;
   logic [XLEN-1:0]       exp_data;
   integer                seed;
   int                    errors;
   int                    failed_tests;
   int                    writes_seen;
   int                    total_len;
   bit                    built;

   mips_core #(
      .IMEM_AW (IMEM_AW)
   ) i_mips_core (
      .i_clock     (clock),
      .i_rst       (rst),
      .i_run       (run),
      .i_load_req  (load_req),
      .i_load_addr (load_addr),
      .i_load_data (load_data),
      .o_load_ack  (load_ack),
      .o_wb_valid  (wb_valid),
      .o_wb_reg    (wb_reg),
      .o_wb_data   (wb_data),
      .o_halted    (halted)
   );

   mips_ref_model #(
      .DEPTH (MAXW)
   ) u_ref_model ();

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   ////////////////////////////////////////////////////////////////////
   // Error reporting and the expected write queue.
   ////////////////////////////////////////////////////////////////////

   function void flag_mismatch(string sig, logic [XLEN-1:0] got, logic [XLEN-1:0] want);
      $display("MISMATCH %s: got %h, expected %h", sig, got, want);
      errors = errors + 1;
   endfunction

   function void flag_failure(string what);
      $display("ERROR at %0t: %s", $time, what);
      errors = errors + 1;
   endfunction

   function void refresh_head();
      exp_count = exp_reg_q.size();
      if (exp_count != 0) begin
         exp_reg  = exp_reg_q[0];
         exp_data = exp_data_q[0];
      end
   endfunction

   // Head is retired after the assertions have sampled it.
   always @(posedge clock) begin
      if (!rst && wb_valid && exp_reg_q.size() != 0) begin
         void'(exp_reg_q.pop_front());
         void'(exp_data_q.pop_front());
         writes_seen = writes_seen + 1;
         refresh_head();
      end
   end

   a_ack_needs_req : assert property (@(posedge clock) disable iff (rst)
      $rose(load_ack) |-> $past(load_req))
      else flag_failure("load ack rose without a request");

   a_ack_follows_req : assert property (@(posedge clock) disable iff (rst)
      $rose(load_req) |=> load_ack)
      else flag_failure("load ack did not answer the request in one cycle");

   a_ack_drops_late : assert property (@(posedge clock) disable iff (rst)
      $fell(load_ack) |-> !$past(load_req))
      else flag_failure("load ack fell while the request was still high");

   a_wb_wanted : assert property (@(posedge clock) disable iff (rst)
      wb_valid |-> exp_count != 0)
      else flag_failure("register write appeared with none expected");

   a_wb_reg : assert property (@(posedge clock) disable iff (rst)
      wb_valid && exp_count != 0 |-> wb_reg == exp_reg)
      else flag_mismatch("o_wb_reg", {27'd0, $sampled(wb_reg)}, {27'd0, $sampled(exp_reg)});

   a_wb_data : assert property (@(posedge clock) disable iff (rst)
      wb_valid && exp_count != 0 |-> wb_data == exp_data)
      else flag_mismatch("o_wb_data", $sampled(wb_data), $sampled(exp_data));

   a_quiet_halted : assert property (@(posedge clock) disable iff (rst)
      halted |-> !wb_valid)
      else flag_failure("register write after the core halted");

   ////////////////////////////////////////////////////////////////////
   // Program construction.
   ////////////////////////////////////////////////////////////////////

   function automatic logic [XLEN-1:0] r_type(logic [5:0] funct, logic [4:0] rd,
                                              logic [4:0] rs, logic [4:0] rt);
      return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic logic [XLEN-1:0] i_type(op_e op, logic [4:0] rt, logic [4:0] rs,
                                              logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [15:0] rand16();
      return 16'($random(seed));
   endfunction

   // One of r1..r3.
   function automatic logic [4:0] pick_src();
      return 5'd1 + 5'({$random(seed)} % 3);
   endfunction

   function automatic void add_word(int t, logic [XLEN-1:0] w);
      progs[t][plen[t]] = w;
      plen[t] = plen[t] + 1;
   endfunction

   // The word after halt must never write back.
   function automatic void close_program(int t);
      add_word(t, HALT);
      add_word(t, i_type(OP_ADDI, 5'd31, 5'd0, 16'h1234));
   endfunction

   task automatic build_programs();
      logic [5:0]  functs [5];
      logic [15:0] v;
      functs = '{FUNCT_ADD, FUNCT_SUB, FUNCT_AND, FUNCT_OR, FUNCT_SLT};
      names[0] = "alu";
      add_word(0, i_type(OP_ADDI, 5'd1, 5'd0, rand16()));
      add_word(0, i_type(OP_ADDI, 5'd2, 5'd0, rand16()));
      add_word(0, i_type(OP_ADDI, 5'd3, 5'd0, rand16() | 16'h8000));
      add_word(0, NOP);
      for (int k = 0; k < 15; k++) begin
         add_word(0, r_type(functs[k % 5], 5'(4 + k), pick_src(), pick_src()));
      end
      // Negative operands for slt, carry out of bit 31 on add.
      add_word(0, r_type(FUNCT_SLT, 5'd19, 5'd3, 5'd1));
      add_word(0, r_type(FUNCT_SLT, 5'd20, 5'd1, 5'd3));
      add_word(0, r_type(FUNCT_ADD, 5'd21, 5'd3, 5'd3));
      close_program(0);
      names[1] = "addi_r0";
      add_word(1, i_type(OP_ADDI, 5'd5, 5'd0, rand16() | 16'h8000));
      add_word(1, i_type(OP_ADDI, 5'd0, 5'd0, rand16()));
      add_word(1, i_type(OP_ADDI, 5'd6, 5'd5, rand16() | 16'h8000));
      add_word(1, r_type(FUNCT_ADD, 5'd0, 5'd5, 5'd5));
      add_word(1, r_type(FUNCT_OR, 5'd7, 5'd0, 5'd0));
      add_word(1, i_type(OP_ADDI, 5'd8, 5'd0, 16'hffff));
      add_word(1, r_type(FUNCT_ADD, 5'd9, 5'd0, 5'd6));
      close_program(1);
      names[2] = "beq";
      v = rand16();
      add_word(2, i_type(OP_ADDI, 5'd1, 5'd0, v));
      add_word(2, i_type(OP_ADDI, 5'd2, 5'd0, v));
      add_word(2, i_type(OP_ADDI, 5'd3, 5'd0, v ^ 16'h0001));
      add_word(2, i_type(OP_BEQ, 5'd2, 5'd1, 16'd3));
      for (int k = 4; k < 7; k++) begin
         add_word(2, i_type(OP_ADDI, 5'(k), 5'd0, rand16()));
      end
      add_word(2, i_type(OP_BEQ, 5'd3, 5'd1, 16'd2));
      add_word(2, i_type(OP_ADDI, 5'd7, 5'd0, rand16()));
      add_word(2, i_type(OP_ADDI, 5'd8, 5'd0, rand16()));
      add_word(2, r_type(FUNCT_ADD, 5'd9, 5'd1, 5'd7));
      close_program(2);
      // Each consumer sits two slots after its producer.
      names[3] = "bypass";
      add_word(3, i_type(OP_ADDI, 5'd1, 5'd0, rand16()));
      add_word(3, NOP);
      add_word(3, i_type(OP_ADDI, 5'd2, 5'd1, rand16()));
      add_word(3, i_type(OP_ADDI, 5'd10, 5'd0, rand16()));
      add_word(3, r_type(FUNCT_SUB, 5'd3, 5'd2, 5'd1));
      add_word(3, NOP);
      add_word(3, r_type(FUNCT_SLT, 5'd4, 5'd3, 5'd2));
      add_word(3, i_type(OP_ADDI, 5'd11, 5'd0, rand16()));
      add_word(3, i_type(OP_BEQ, 5'd0, 5'd4, 16'd1));
      add_word(3, i_type(OP_ADDI, 5'd12, 5'd0, rand16()));
      add_word(3, i_type(OP_ADDI, 5'd13, 5'd0, rand16()));
      close_program(3);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Loading and running.
   ////////////////////////////////////////////////////////////////////

   task automatic load_word(input logic [IMEM_AW-1:0] addr, input logic [XLEN-1:0] data);
      load_addr = addr;
      load_data = data;
      load_req  = 1'b1;
      @(negedge clock);
      while (!load_ack) @(negedge clock);
      load_req = 1'b0;
      @(negedge clock);
      while (load_ack) @(negedge clock);
   endtask

   task automatic run_test(input int t);
      int                    errs_before;
      int                    seen_before;
      logic [REG_ADDR_W-1:0] r;
      logic [XLEN-1:0]       d;
      errs_before = errors;
      seen_before = writes_seen;
      rst = 1'b1;
      repeat (16) @(negedge clock);
      rst = 1'b0;
      u_ref_model.clear();
      for (int i = 0; i < plen[t]; i++) begin
         u_ref_model.load(i, progs[t][i]);
         load_word(IMEM_AW'(i), progs[t][i]);
      end
      u_ref_model.run();
      exp_reg_q.delete();
      exp_data_q.delete();
      while (u_ref_model.next_write(r, d)) begin
         exp_reg_q.push_back(r);
         exp_data_q.push_back(d);
      end
      refresh_head();
      run = 1'b1;
      while (!halted) @(negedge clock);
      repeat (3) @(negedge clock);
      assert (exp_reg_q.size() == 0)
         else flag_failure($sformatf("%0d expected writes never appeared", exp_reg_q.size()));
      run = 1'b0;
      if (errors != errs_before) failed_tests = failed_tests + 1;
      $display("test %0d %s: %0d writes checked, %0d errors", t, names[t],
               writes_seen - seen_before, errors - errs_before);
   endtask

   // Watchdog sized from the total program length.
   initial begin
      wait (built);
      #(4 * (total_len + 20) * 20);
      $display("watchdog expired before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      run          = 1'b0;
      load_req     = 1'b0;
      load_addr    = '0;
      load_data    = '0;
      seed         = 32'h9d4c_09d6;
      errors       = 0;
      failed_tests = 0;
      writes_seen  = 0;
      exp_count    = 0;
      total_len    = 0;
      built        = 1'b0;
      for (int t = 0; t < NTESTS; t++) begin
         plen[t] = 0;
      end
      build_programs();
      for (int t = 0; t < NTESTS; t++) begin
         total_len = total_len + plen[t];
      end
      built = 1'b1;
      for (int t = 0; t < NTESTS; t++) begin
         run_test(t);
      end
      $display("%0d tests run, %0d failed, %0d errors", NTESTS, failed_tests, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- build.f
logic/mips_pkg.sv
logic/stage_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mips_core.sv
tb/mips_ref_model.sv
tb/tb_mips_core.sv
